//--- verilog/rv_isa_pkg.sv
////////////////////
// RV32I instruction set encoding
// Data and instruction widths, register indices and the
// major opcodes decoded by the ID stage
////////////////////

package rv_isa_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned NUM_REGS   = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // Size of one uncompressed instruction in bytes
  localparam logic [XLEN-1:0] INSN_BYTES = 32'd4;

  ////////////////////
  // Word types
  ////////////////////

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [31:0]           instr_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  ////////////////////
  // Major opcodes
  ////////////////////

  // Only the RV32I base opcodes kept by this stage
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

endpackage

//--- verilog/id_ctrl_pkg.sv
////////////////////
// ID stage control definitions
// Select encodings, decoded instruction fields, the execute
// and load/store request formats and the FSM states
////////////////////

package id_ctrl_pkg;

  import rv_isa_pkg::*;

  ////////////////////
  // Select enums
  ////////////////////

  // Arithmetic/logic ops first, then branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURR_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_INCR_PC
  } imm_sel_e;

  typedef enum logic {WB_EX, WB_LSU} wb_sel_e;

  typedef enum logic [2:0] {
    CLASS_ALU, CLASS_LOAD_STORE, CLASS_BRANCH, CLASS_JUMP, CLASS_ILLEGAL
  } insn_class_e;

  // Same access size coding as the LSU
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  typedef enum logic {PC_BRANCH, PC_JUMP} pc_mux_e;
  typedef enum logic {IDLE, WAIT_DONE} id_state_e;

  ////////////////////
  // Structs
  ////////////////////

  typedef struct packed {
    insn_class_e insn_class;
    alu_op_e     alu_op;
    op_a_sel_e   op_a_sel;
    op_b_sel_e   op_b_sel;
    imm_sel_e    imm_sel;
    logic        rf_we;
    wb_sel_e     wb_sel;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    logic        lsu_we;
    lsu_type_e   lsu_type;
    logic        lsu_sign_ext;
  } decoded_t;

  typedef struct packed {
    logic    valid;
    alu_op_e alu_op;
    word_t   operand_a;
    word_t   operand_b;
  } ex_req_t;

  // Address comes from the ALU result, so only access info here
  typedef struct packed {
    logic      valid;
    logic      we;
    lsu_type_e lsu_type;
    logic      sign_ext;
    word_t     wdata;
  } lsu_req_t;

endpackage

//--- verilog/id_decoder.sv
////////////////////
// Instruction decoder
// Maps an RV32I instruction word to the control struct and
// the selected sign-extended immediate
////////////////////

`timescale 1ns/1ps

module id_decoder
  import rv_isa_pkg::*, id_ctrl_pkg::*;
(
  input  instr_t   instr_i,
  output decoded_t dec_o,
  output word_t    imm_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal;

  word_t imm_i_type;
  word_t imm_s_type;
  word_t imm_b_type;
  word_t imm_u_type;
  word_t imm_j_type;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  ////////////////////
  // Immediates
  ////////////////////

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  always_comb begin
    case (dec_o.imm_sel)
      IMM_I:       imm_o = imm_i_type;
      IMM_S:       imm_o = imm_s_type;
      IMM_B:       imm_o = imm_b_type;
      IMM_U:       imm_o = imm_u_type;
      IMM_J:       imm_o = imm_j_type;
      IMM_INCR_PC: imm_o = INSN_BYTES;
      default:     imm_o = '0;
    endcase
  end

  ////////////////////
  // Control decode
  ////////////////////

  always_comb begin
    illegal            = 1'b0;
    dec_o.insn_class   = CLASS_ALU;
    dec_o.alu_op       = ALU_ADD;
    dec_o.op_a_sel     = OP_A_REG_A;
    dec_o.op_b_sel     = OP_B_REG_B;
    dec_o.imm_sel      = IMM_I;
    dec_o.rf_we        = 1'b0;
    dec_o.wb_sel       = WB_EX;
    dec_o.rs1          = instr_i[19:15];
    dec_o.rs2          = instr_i[24:20];
    dec_o.rd           = instr_i[11:7];
    dec_o.lsu_we       = 1'b0;
    dec_o.lsu_type     = LSU_WORD;
    dec_o.lsu_sign_ext = 1'b0;

    case (opcode)
      OPCODE_OP: begin
        dec_o.rf_we = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: dec_o.alu_op = ALU_ADD;
          {7'h20, 3'b000}: dec_o.alu_op = ALU_SUB;
          {7'h00, 3'b001}: dec_o.alu_op = ALU_SLL;
          {7'h00, 3'b010}: dec_o.alu_op = ALU_SLT;
          {7'h00, 3'b011}: dec_o.alu_op = ALU_SLTU;
          {7'h00, 3'b100}: dec_o.alu_op = ALU_XOR;
          {7'h00, 3'b101}: dec_o.alu_op = ALU_SRL;
          {7'h20, 3'b101}: dec_o.alu_op = ALU_SRA;
          {7'h00, 3'b110}: dec_o.alu_op = ALU_OR;
          {7'h00, 3'b111}: dec_o.alu_op = ALU_AND;
          default:         illegal = 1'b1;
        endcase
      end
      OPCODE_OP_IMM: begin
        dec_o.rf_we    = 1'b1;
        dec_o.op_b_sel = OP_B_IMM;
        case (funct3)
          3'b000: dec_o.alu_op = ALU_ADD;
          3'b010: dec_o.alu_op = ALU_SLT;
          3'b011: dec_o.alu_op = ALU_SLTU;
          3'b100: dec_o.alu_op = ALU_XOR;
          3'b110: dec_o.alu_op = ALU_OR;
          3'b111: dec_o.alu_op = ALU_AND;
          3'b001: begin
            dec_o.alu_op = ALU_SLL;
            illegal      = (funct7 != 7'h00);
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            dec_o.alu_op = (funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
            illegal      = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        dec_o.rf_we    = 1'b1;
        dec_o.op_a_sel = (opcode == OPCODE_LUI) ? OP_A_ZERO : OP_A_CURR_PC;
        dec_o.op_b_sel = OP_B_IMM;
        dec_o.imm_sel  = IMM_U;
      end
      OPCODE_LOAD: begin
        dec_o.insn_class   = CLASS_LOAD_STORE;
        dec_o.rf_we        = 1'b1;
        dec_o.wb_sel       = WB_LSU;
        dec_o.op_b_sel     = OP_B_IMM;
        dec_o.lsu_sign_ext = ~funct3[2];
        case (funct3)
          3'b000, 3'b100: dec_o.lsu_type = LSU_BYTE;
          3'b001, 3'b101: dec_o.lsu_type = LSU_HALF;
          3'b010:         dec_o.lsu_type = LSU_WORD;
          default:        illegal = 1'b1;
        endcase
      end
      OPCODE_STORE: begin
        dec_o.insn_class = CLASS_LOAD_STORE;
        dec_o.lsu_we     = 1'b1;
        dec_o.op_b_sel   = OP_B_IMM;
        dec_o.imm_sel    = IMM_S;
        case (funct3)
          3'b000:  dec_o.lsu_type = LSU_BYTE;
          3'b001:  dec_o.lsu_type = LSU_HALF;
          3'b010:  dec_o.lsu_type = LSU_WORD;
          default: illegal = 1'b1;
        endcase
      end
      OPCODE_BRANCH: begin
        dec_o.insn_class = CLASS_BRANCH;
        dec_o.imm_sel    = IMM_B;
        case (funct3)
          3'b000:  dec_o.alu_op = ALU_EQ;
          3'b001:  dec_o.alu_op = ALU_NE;
          3'b100:  dec_o.alu_op = ALU_LT;
          3'b101:  dec_o.alu_op = ALU_GE;
          3'b110:  dec_o.alu_op = ALU_LTU;
          3'b111:  dec_o.alu_op = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end
      OPCODE_JAL, OPCODE_JALR: begin
        // ALU produces the link value PC + 4
        dec_o.insn_class = CLASS_JUMP;
        dec_o.rf_we      = 1'b1;
        dec_o.op_a_sel   = OP_A_CURR_PC;
        dec_o.op_b_sel   = OP_B_IMM;
        dec_o.imm_sel    = IMM_INCR_PC;
        illegal          = (opcode == OPCODE_JALR) && (funct3 != 3'b000);
      end
      default: illegal = 1'b1;
    endcase

    if (illegal) begin
      dec_o.insn_class = CLASS_ILLEGAL;
      dec_o.rf_we      = 1'b0;
      dec_o.lsu_we     = 1'b0;
    end
  end

endmodule

//--- verilog/id_register_file.sv
////////////////////
// Register file
// 32 x 32 bit, two read ports and one write port
// x0 reads as zero and ignores writes
////////////////////

`timescale 1ns/1ps

module id_register_file
  import rv_isa_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  output word_t     rdata_a_o,
  output word_t     rdata_b_o,

  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous reads
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

//--- verilog/id_operand_mux.sv
////////////////////
// Operand selection
// Picks the ALU operands and builds the execute and
// load/store requests for the held instruction
////////////////////

`timescale 1ns/1ps

module id_operand_mux
  import rv_isa_pkg::*, id_ctrl_pkg::*;
(
  input  decoded_t dec_i,
  input  word_t    imm_i,
  input  word_t    pc_i,
  input  word_t    rdata_a_i,
  input  word_t    rdata_b_i,
  input  logic     issue_i,
  output ex_req_t  ex_req_o,
  output lsu_req_t lsu_req_o
);

  word_t operand_a;
  word_t operand_b;

  // Operand A
  always_comb begin
    case (dec_i.op_a_sel)
      OP_A_REG_A:   operand_a = rdata_a_i;
      OP_A_CURR_PC: operand_a = pc_i;
      default:      operand_a = '0;
    endcase
  end

  // Operand B
  assign operand_b = (dec_i.op_b_sel == OP_B_IMM) ? imm_i : rdata_b_i;

  ////////////////////
  // Requests
  ////////////////////

  assign ex_req_o.valid     = issue_i;
  assign ex_req_o.alu_op    = dec_i.alu_op;
  assign ex_req_o.operand_a = operand_a;
  assign ex_req_o.operand_b = operand_b;

  // Store data always from rs2
  assign lsu_req_o.valid    = issue_i && (dec_i.insn_class == CLASS_LOAD_STORE);
  assign lsu_req_o.we       = dec_i.lsu_we;
  assign lsu_req_o.lsu_type = dec_i.lsu_type;
  assign lsu_req_o.sign_ext = dec_i.lsu_sign_ext;
  assign lsu_req_o.wdata    = rdata_b_i;

endmodule

//--- verilog/id_controller.sv
////////////////////
// ID stage controller
// Holds the accepted instruction, issues it and waits for
// completion, then drives write-back and the PC redirect
////////////////////

`timescale 1ns/1ps

module id_controller
  import rv_isa_pkg::*, id_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  // Instruction input
  input  logic      instr_valid_i,
  input  instr_t    instr_i,
  input  word_t     pc_i,
  output logic      id_ready_o,

  // Held instruction to the datapath
  output instr_t    instr_o,
  output word_t     pc_o,
  input  decoded_t  dec_i,
  output logic      issue_o,

  // Completion
  input  logic      ex_valid_i,
  input  word_t     ex_result_i,
  input  logic      branch_decision_i,
  input  logic      lsu_valid_i,
  input  word_t     lsu_rdata_i,

  // Write-back
  output logic      rf_we_o,
  output reg_addr_t rf_waddr_o,
  output word_t     rf_wdata_o,

  output logic      pc_set_o,
  output pc_mux_e   pc_mux_o,
  output logic      illegal_insn_o
);

  id_state_e state_q;
  id_state_e state_d;
  instr_t    instr_q;
  word_t     pc_q;
  logic      complete;
  logic      done;

  ////////////////////
  // Hold registers
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (id_ready_o && instr_valid_i) begin
      instr_q <= instr_i;
      pc_q    <= pc_i;
    end
  end

  assign instr_o = instr_q;
  assign pc_o    = pc_q;

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign id_ready_o     = (state_q == IDLE);
  assign illegal_insn_o = (state_q == WAIT_DONE) && (dec_i.insn_class == CLASS_ILLEGAL);
  assign issue_o        = (state_q == WAIT_DONE) && (dec_i.insn_class != CLASS_ILLEGAL);

  // Loads and stores finish on the LSU, everything else on EX
  assign complete = (dec_i.insn_class == CLASS_LOAD_STORE) ? lsu_valid_i : ex_valid_i;
  assign done     = issue_o && complete;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (instr_valid_i) state_d = WAIT_DONE;
      WAIT_DONE: if (illegal_insn_o || done) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  ////////////////////
  // Write-back and redirect
  ////////////////////

  assign rf_we_o    = done && dec_i.rf_we;
  assign rf_waddr_o = dec_i.rd;
  assign rf_wdata_o = (dec_i.wb_sel == WB_LSU) ? lsu_rdata_i : ex_result_i;

  assign pc_set_o = done && ((dec_i.insn_class == CLASS_JUMP) ||
                             ((dec_i.insn_class == CLASS_BRANCH) && branch_decision_i));
  assign pc_mux_o = (dec_i.insn_class == CLASS_JUMP) ? PC_JUMP : PC_BRANCH;

endmodule

//--- verilog/id_stage.sv
////////////////////
// Instruction decode stage
// Controller, decoder, register file and operand mux
////////////////////

`timescale 1ns/1ps

module id_stage
  import rv_isa_pkg::*, id_ctrl_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     instr_valid_i,
  input  instr_t   instr_i,
  input  word_t    pc_i,
  output logic     id_ready_o,

  output ex_req_t  ex_req_o,
  output lsu_req_t lsu_req_o,

  input  logic     ex_valid_i,
  input  word_t    ex_result_i,
  input  logic     branch_decision_i,
  input  logic     lsu_valid_i,
  input  word_t    lsu_rdata_i,

  output logic     pc_set_o,
  output pc_mux_e  pc_mux_o,
  output logic     illegal_insn_o
);

  instr_t    instr_id;
  word_t     pc_id;
  decoded_t  dec;
  word_t     imm;
  logic      issue;
  word_t     rdata_a;
  word_t     rdata_b;
  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  id_controller u_controller (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .instr_i           (instr_i),
    .pc_i              (pc_i),
    .id_ready_o        (id_ready_o),
    .instr_o           (instr_id),
    .pc_o              (pc_id),
    .dec_i             (dec),
    .issue_o           (issue),
    .ex_valid_i        (ex_valid_i),
    .ex_result_i       (ex_result_i),
    .branch_decision_i (branch_decision_i),
    .lsu_valid_i       (lsu_valid_i),
    .lsu_rdata_i       (lsu_rdata_i),
    .rf_we_o           (rf_we),
    .rf_waddr_o        (rf_waddr),
    .rf_wdata_o        (rf_wdata),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .illegal_insn_o    (illegal_insn_o)
  );

  id_decoder u_decoder (
    .instr_i (instr_id),
    .dec_o   (dec),
    .imm_o   (imm)
  );

  id_register_file u_register_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (dec.rs1),
    .raddr_b_i (dec.rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  id_operand_mux u_operand_mux (
    .dec_i     (dec),
    .imm_i     (imm),
    .pc_i      (pc_id),
    .rdata_a_i (rdata_a),
    .rdata_b_i (rdata_b),
    .issue_i   (issue),
    .ex_req_o  (ex_req_o),
    .lsu_req_o (lsu_req_o)
  );

endmodule

//--- sim/id_stage_chk.sv
////////////////////
// ID stage protocol checks
// Bound assertions on the input handshake and request stability
////////////////////

`timescale 1ns/1ps

module id_stage_chk
  import id_ctrl_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input logic     id_ready_o,
  input ex_req_t  ex_req_o,
  input lsu_req_t lsu_req_o,
  input logic     ex_valid_i,
  input logic     lsu_valid_i,
  input logic     pc_set_o,
  input logic     illegal_insn_o
);

  logic busy;
  logic complete;

  assign busy     = ex_req_o.valid || lsu_req_o.valid;
  // Loads and stores finish on the LSU side
  assign complete = lsu_req_o.valid ? lsu_valid_i : ex_valid_i;

  ready_low_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy |-> !id_ready_o)
    else $error("id_ready_o high while a request is valid");

  ex_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ex_req_o.valid && !complete) |=> $stable(ex_req_o))
    else $error("ex_req_o changed before completion");

  pc_set_needs_completion: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_o |-> (ex_valid_i || lsu_valid_i))
    else $error("pc_set_o high without a completion input");

  illegal_without_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_insn_o |-> !busy)
    else $error("illegal_insn_o high together with a valid request");

endmodule

bind id_stage id_stage_chk u_chk (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .id_ready_o     (id_ready_o),
  .ex_req_o       (ex_req_o),
  .lsu_req_o      (lsu_req_o),
  .ex_valid_i     (ex_valid_i),
  .lsu_valid_i    (lsu_valid_i),
  .pc_set_o       (pc_set_o),
  .illegal_insn_o (illegal_insn_o)
);

//--- sim/id_stage_tb.sv
////////////////////
// ID stage testbench
// Directed tests with a register model and a responder that
// completes each request after a random delay
////////////////////

`timescale 1ns/1ps

module id_stage_tb
  import rv_isa_pkg::*, id_ctrl_pkg::*;
();

  // About 60 instructions at most 12 cycles each, plus margin
  localparam int TIMEOUT_CYCLES = 3000;
  localparam lsu_req_t NO_LSU = '0;

  logic     clk_i;
  logic     rst_ni;
  logic     instr_valid_i;
  instr_t   instr_i;
  word_t    pc_i;
  logic     id_ready_o;
  ex_req_t  ex_req_o;
  lsu_req_t lsu_req_o;
  logic     ex_valid_i;
  word_t    ex_result_i;
  logic     branch_decision_i;
  logic     lsu_valid_i;
  word_t    lsu_rdata_i;
  logic     pc_set_o;
  pc_mux_e  pc_mux_o;
  logic     illegal_insn_o;

  word_t model [NUM_REGS];
  word_t pc_now;
  int    seed;
  int    cycle_count;

  id_stage u_dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .instr_i           (instr_i),
    .pc_i              (pc_i),
    .id_ready_o        (id_ready_o),
    .ex_req_o          (ex_req_o),
    .lsu_req_o         (lsu_req_o),
    .ex_valid_i        (ex_valid_i),
    .ex_result_i       (ex_result_i),
    .branch_decision_i (branch_decision_i),
    .lsu_valid_i       (lsu_valid_i),
    .lsu_rdata_i       (lsu_rdata_i),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .illegal_insn_o    (illegal_insn_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("TESTBENCH FAILED");
      $fatal(1, "Simulation timeout");
    end
  end

  ////////////////////
  // Reference models
  ////////////////////

  function automatic word_t sext12(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_XOR:  return a ^ b;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
      ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: return {31'b0, a < b};
      default:  return '0;
    endcase
  endfunction

  function automatic logic branch_model(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return $signed(a) < $signed(b);
      ALU_GE:  return $signed(a) >= $signed(b);
      ALU_LTU: return a < b;
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic ex_req_t mk_ex(alu_op_e op, word_t a, word_t b);
    return '{valid: 1'b1, alu_op: op, operand_a: a, operand_b: b};
  endfunction

  function automatic lsu_req_t mk_lsu(logic we, lsu_type_e t, logic sext, word_t wdata);
    return '{valid: 1'b1, we: we, lsu_type: t, sign_ext: sext, wdata: wdata};
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "Check failed");
  endtask

  task automatic check_ex_req(input string name, input ex_req_t exp, input ex_req_t act);
    // Operands only matter while the request is valid
    if ((exp.valid && act !== exp) || (!exp.valid && act.valid !== 1'b0)) begin
      report_failure($sformatf("Mismatch [%s] ex_req expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_lsu_req(input string name, input lsu_req_t exp, input lsu_req_t act);
    lsu_req_t cmp;
    cmp = act;
    if (!exp.valid) begin
      cmp       = exp;
      cmp.valid = act.valid;
    end else if (!exp.we) begin
      // Store data is a don't care for loads
      cmp.wdata = exp.wdata;
    end
    if (cmp !== exp) begin
      report_failure($sformatf("Mismatch [%s] lsu_req expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      report_failure($sformatf("Mismatch [%s] expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_pc_mux(input string name, input pc_mux_e exp, input pc_mux_e act);
    if (act !== exp) begin
      report_failure($sformatf("Mismatch [%s] pc_mux expected %s actual %s",
                               name, exp.name(), act.name()));
    end
  endtask

  ////////////////////
  // Driver and responder
  ////////////////////

  task automatic accept(input instr_t instr);
    @(posedge clk_i);
    instr_valid_i <= 1'b1;
    instr_i       <= instr;
    pc_i          <= pc_now;
    @(negedge clk_i);
    while (!id_ready_o) begin
      @(negedge clk_i);
    end
    // Transfer edge
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
  endtask

  task automatic run_insn(input string name, input instr_t instr, input insn_class_e cls,
                          input ex_req_t exp_ex, input lsu_req_t exp_lsu);
    logic [31:0] rnd;
    word_t       result;
    logic        decision;
    logic        exp_set;
    int          delay;
    reg_addr_t   rd;
    rd    = instr[11:7];
    rnd   = $random(seed);
    delay = int'(rnd % 32'd6);
    rnd   = $random(seed);
    if (cls == CLASS_LOAD_STORE || cls == CLASS_BRANCH) begin
      result = $random(seed);
    end else begin
      result = alu_model(exp_ex.alu_op, exp_ex.operand_a, exp_ex.operand_b);
    end
    // Noise on branch_decision_i for everything but branches
    decision = (cls == CLASS_BRANCH) ?
               branch_model(exp_ex.alu_op, exp_ex.operand_a, exp_ex.operand_b) : rnd[0];
    exp_set  = (cls == CLASS_JUMP) || ((cls == CLASS_BRANCH) && decision);

    accept(instr);
    repeat (delay) begin
      @(negedge clk_i);
      check_ex_req(name, exp_ex, ex_req_o);
      check_lsu_req(name, exp_lsu, lsu_req_o);
      check_word({name, " id_ready"}, '0, word_t'(id_ready_o));
      @(posedge clk_i);
    end
    if (cls == CLASS_LOAD_STORE) begin
      lsu_valid_i <= 1'b1;
      lsu_rdata_i <= result;
    end else begin
      ex_valid_i        <= 1'b1;
      ex_result_i       <= result;
      branch_decision_i <= decision;
    end
    @(negedge clk_i);
    check_ex_req(name, exp_ex, ex_req_o);
    check_lsu_req(name, exp_lsu, lsu_req_o);
    check_word({name, " pc_set"}, word_t'(exp_set), word_t'(pc_set_o));
    if (exp_set) begin
      check_pc_mux(name, (cls == CLASS_JUMP) ? PC_JUMP : PC_BRANCH, pc_mux_o);
    end
    @(posedge clk_i);
    ex_valid_i        <= 1'b0;
    lsu_valid_i       <= 1'b0;
    branch_decision_i <= 1'b0;
    if (rd != '0 && (cls == CLASS_ALU || cls == CLASS_JUMP ||
                     (cls == CLASS_LOAD_STORE && !exp_lsu.we))) begin
      model[rd] = result;
    end
    @(negedge clk_i);
    if (!id_ready_o) begin
      report_failure($sformatf("Stage in %s did not return to ready after completion", name));
    end
    pc_now = pc_now + 32'd4;
  endtask

  ////////////////////
  // Instruction helpers
  ////////////////////

  task automatic do_op(input string name, input logic [6:0] f7, input logic [2:0] f3,
                       input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2,
                       input alu_op_e op);
    run_insn(name, {f7, rs2, rs1, f3, rd, 7'h33}, CLASS_ALU,
             mk_ex(op, model[rs1], model[rs2]), NO_LSU);
  endtask

  task automatic do_op_imm(input string name, input logic [2:0] f3, input logic [11:0] imm,
                           input reg_addr_t rd, input reg_addr_t rs1, input alu_op_e op);
    run_insn(name, {imm, rs1, f3, rd, 7'h13}, CLASS_ALU,
             mk_ex(op, model[rs1], sext12(imm)), NO_LSU);
  endtask

  task automatic do_load(input string name, input logic [2:0] f3, input logic [11:0] imm,
                         input reg_addr_t rd, input reg_addr_t rs1, input lsu_type_e t,
                         input logic sext);
    run_insn(name, {imm, rs1, f3, rd, 7'h03}, CLASS_LOAD_STORE,
             mk_ex(ALU_ADD, model[rs1], sext12(imm)), mk_lsu(1'b0, t, sext, '0));
  endtask

  task automatic do_store(input string name, input logic [2:0] f3, input logic [11:0] imm,
                          input reg_addr_t rs2, input reg_addr_t rs1, input lsu_type_e t);
    run_insn(name, {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23}, CLASS_LOAD_STORE,
             mk_ex(ALU_ADD, model[rs1], sext12(imm)), mk_lsu(1'b1, t, 1'b0, model[rs2]));
  endtask

  // Fixed offset 0x1e puts x30 in the rd field
  task automatic do_branch(input string name, input logic [2:0] f3, input reg_addr_t rs1,
                           input reg_addr_t rs2, input alu_op_e op);
    logic [12:0] imm;
    imm = 13'h1e;
    run_insn(name, {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63},
             CLASS_BRANCH, mk_ex(op, model[rs1], model[rs2]), NO_LSU);
  endtask

  task automatic do_illegal(input string name, input instr_t instr);
    accept(instr);
    @(negedge clk_i);
    check_word({name, " illegal"}, 32'd1, word_t'(illegal_insn_o));
    check_ex_req(name, '0, ex_req_o);
    check_lsu_req(name, NO_LSU, lsu_req_o);
    @(negedge clk_i);
    check_word({name, " illegal end"}, '0, word_t'(illegal_insn_o));
    check_word({name, " ready"}, 32'd1, word_t'(id_ready_o));
    pc_now = pc_now + 32'd4;
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic test_alu();
    do_op_imm("addi", 3'b000, 12'h123, 5'd1, 5'd0, ALU_ADD);
    do_op_imm("addi_neg", 3'b000, 12'hffb, 5'd2, 5'd0, ALU_ADD);
    do_op("add", 7'h00, 3'b000, 5'd3, 5'd1, 5'd2, ALU_ADD);
    do_op("sub", 7'h20, 3'b000, 5'd4, 5'd1, 5'd2, ALU_SUB);
    do_op("xor", 7'h00, 3'b100, 5'd5, 5'd3, 5'd4, ALU_XOR);
    do_op("or", 7'h00, 3'b110, 5'd6, 5'd5, 5'd4, ALU_OR);
    do_op("and", 7'h00, 3'b111, 5'd7, 5'd6, 5'd3, ALU_AND);
    do_op("sll", 7'h00, 3'b001, 5'd8, 5'd2, 5'd1, ALU_SLL);
    do_op("srl", 7'h00, 3'b101, 5'd9, 5'd2, 5'd1, ALU_SRL);
    do_op("sra", 7'h20, 3'b101, 5'd10, 5'd2, 5'd1, ALU_SRA);
    do_op("slt", 7'h00, 3'b010, 5'd11, 5'd2, 5'd1, ALU_SLT);
    do_op("sltu", 7'h00, 3'b011, 5'd12, 5'd2, 5'd1, ALU_SLTU);
    do_op_imm("slti", 3'b010, 12'h001, 5'd13, 5'd2, ALU_SLT);
    do_op_imm("sltiu", 3'b011, 12'h7ff, 5'd14, 5'd1, ALU_SLTU);
    do_op_imm("xori", 3'b100, 12'hfff, 5'd15, 5'd1, ALU_XOR);
    do_op_imm("ori", 3'b110, 12'h0f0, 5'd16, 5'd11, ALU_OR);
    do_op_imm("andi", 3'b111, 12'h0f0, 5'd17, 5'd3, ALU_AND);
    do_op_imm("slli", 3'b001, 12'h004, 5'd18, 5'd1, ALU_SLL);
    do_op_imm("srli", 3'b101, 12'h008, 5'd19, 5'd2, ALU_SRL);
    do_op_imm("srai", 3'b101, 12'h408, 5'd20, 5'd2, ALU_SRA);
    do_op("add_use", 7'h00, 3'b000, 5'd21, 5'd20, 5'd19, ALU_ADD);
  endtask

  task automatic test_upper_jump();
    run_insn("lui", {20'habcde, 5'd22, 7'h37}, CLASS_ALU,
             mk_ex(ALU_ADD, '0, 32'habcde000), NO_LSU);
    run_insn("auipc", {20'h12345, 5'd23, 7'h17}, CLASS_ALU,
             mk_ex(ALU_ADD, pc_now, 32'h12345000), NO_LSU);
    // jal x24 with offset 0x100
    run_insn("jal", {1'b0, 10'h080, 1'b0, 8'h00, 5'd24, 7'h6f}, CLASS_JUMP,
             mk_ex(ALU_ADD, pc_now, 32'd4), NO_LSU);
    run_insn("jalr", {12'h010, 5'd22, 3'b000, 5'd25, 7'h67}, CLASS_JUMP,
             mk_ex(ALU_ADD, pc_now, 32'd4), NO_LSU);
    do_op("link_use", 7'h00, 3'b000, 5'd26, 5'd24, 5'd25, ALU_ADD);
  endtask

  task automatic test_load_store();
    // Store rd fields land on x8 and x28, neither may change
    do_store("sw", 3'b010, 12'h008, 5'd3, 5'd1, LSU_WORD);
    do_store("sb", 3'b000, 12'hffc, 5'd4, 5'd22, LSU_BYTE);
    do_store("sh", 3'b001, 12'h020, 5'd5, 5'd23, LSU_HALF);
    do_op("store_rd_use", 7'h00, 3'b000, 5'd29, 5'd8, 5'd28, ALU_ADD);
    do_load("lw", 3'b010, 12'h000, 5'd27, 5'd1, LSU_WORD, 1'b1);
    do_load("lb", 3'b000, 12'h003, 5'd28, 5'd2, LSU_BYTE, 1'b1);
    do_load("lbu", 3'b100, 12'hff0, 5'd11, 5'd3, LSU_BYTE, 1'b0);
    do_load("lh", 3'b001, 12'h002, 5'd12, 5'd4, LSU_HALF, 1'b1);
    do_load("lhu", 3'b101, 12'h7fe, 5'd13, 5'd5, LSU_HALF, 1'b0);
    do_op("load_use", 7'h00, 3'b000, 5'd29, 5'd27, 5'd28, ALU_ADD);
    do_op("load_use2", 7'h00, 3'b100, 5'd14, 5'd11, 5'd12, ALU_XOR);
  endtask

  task automatic test_branch();
    do_branch("beq", 3'b000, 5'd1, 5'd1, ALU_EQ);
    do_branch("bne", 3'b001, 5'd1, 5'd1, ALU_NE);
    do_branch("blt", 3'b100, 5'd2, 5'd1, ALU_LT);
    do_branch("bge", 3'b101, 5'd2, 5'd1, ALU_GE);
    do_branch("bltu", 3'b110, 5'd2, 5'd1, ALU_LTU);
    do_branch("bgeu", 3'b111, 5'd2, 5'd1, ALU_GEU);
    do_op("branch_rd_use", 7'h00, 3'b000, 5'd31, 5'd30, 5'd1, ALU_ADD);
  endtask

  task automatic test_x0();
    do_op_imm("addi_x0", 3'b000, 12'h005, 5'd0, 5'd1, ALU_ADD);
    do_op("x0_read", 7'h00, 3'b000, 5'd21, 5'd0, 5'd1, ALU_ADD);
  endtask

  task automatic test_illegal();
    do_illegal("custom_opcode", {12'h000, 5'd1, 3'b000, 5'd5, 7'h0b});
    do_op("after_custom", 7'h00, 3'b000, 5'd21, 5'd5, 5'd0, ALU_ADD);
    // Multiply encoding, the M extension is not decoded
    do_illegal("mul", {7'h01, 5'd2, 5'd1, 3'b000, 5'd6, 7'h33});
    do_op("after_mul", 7'h00, 3'b110, 5'd21, 5'd6, 5'd1, ALU_OR);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    seed              = 92;
    cycle_count       = 0;
    pc_now            = 32'h0000_1000;
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_i           = '0;
    pc_i              = '0;
    ex_valid_i        = 1'b0;
    ex_result_i       = '0;
    branch_decision_i = 1'b0;
    lsu_valid_i       = 1'b0;
    lsu_rdata_i       = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model[i] = '0;
    end

    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_word("reset ready", 32'd1, word_t'(id_ready_o));
    check_word("reset pc_set", '0, word_t'(pc_set_o));
    check_word("reset illegal", '0, word_t'(illegal_insn_o));
    check_ex_req("reset", '0, ex_req_o);
    check_lsu_req("reset", NO_LSU, lsu_req_o);

    test_alu();
    test_upper_jump();
    test_load_store();
    test_branch();
    test_x0();
    test_illegal();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- compile.f
verilog/rv_isa_pkg.sv
verilog/id_ctrl_pkg.sv
verilog/id_decoder.sv
verilog/id_register_file.sv
verilog/id_operand_mux.sv
verilog/id_controller.sv
verilog/id_stage.sv
sim/id_stage_chk.sv
sim/id_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the ID stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f compile.f --top-module id_stage_tb \
    -o id_stage_sim; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/id_stage_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
